// ==== color_mask_top.f ====
mask_pkg.sv
display_timing.sv
frame_writer.sv
frame_buffer.sv
frame_reader.sv
rgb_to_ycrcb.sv
channel_mask.sv
video_mux.sv
color_mask_top.sv
tb_color_mask_top.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --timescale 1ns/1ps -j 0 \
		--top-module tb_color_mask_top -f color_mask_top.f -o sim_tb
	./obj_dir/sim_tb

clean:
	rm -rf obj_dir

// ==== tb_color_mask_top.sv ====
`timescale 1ns/1ps

module tb_color_mask_top;

    import mask_pkg::*;

    // default raster and frame sizes of the DUT
    localparam int FRAME_WIDTH  = 16;
    localparam int FRAME_HEIGHT = 8;
    localparam int H_ACTIVE     = 72;
    localparam int H_TOTAL      = 88;
    localparam int V_ACTIVE     = 36;
    localparam int V_TOTAL      = 40;
    localparam int H_SYNC       = 8;
    localparam int V_SYNC       = 2;
    localparam int SCALE        = 4;
    localparam int CAM_WIDTH    = FRAME_WIDTH * SCALE;
    localparam int CAM_HEIGHT   = FRAME_HEIGHT * SCALE;

    localparam int NUM_TESTS    = 6;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    // camera load and two frames per row plus some margin
    localparam int CYCLE_LIMIT  = CAM_WIDTH * CAM_HEIGHT + 2 * FRAME_CYCLES * NUM_TESTS + 1000;

    // settings table with one row per test
    string test_names [NUM_TESTS] = '{"camera", "grey_red", "grey_cr",
                                      "grey_invalid", "mask_y", "target_cb"};
    localparam logic [2:0] CH_CODES  [NUM_TESTS] = '{3'd1, 3'd1, 3'd5, 3'd3, 3'd4, 3'd6};
    localparam logic [1:0] BG_CODES  [NUM_TESTS] = '{2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd0};
    localparam logic [1:0] TGT_CODES [NUM_TESTS] = '{2'd0, 2'd0, 2'd0, 2'd0, 2'd0, 2'd1};
    localparam logic [7:0] LOWER     [NUM_TESTS] = '{8'd0, 8'd0, 8'd0, 8'd0, 8'd64, 8'd128};
    localparam logic [7:0] UPPER     [NUM_TESTS] = '{8'd255, 8'd255, 8'd255, 8'd255,
                                                     8'd191, 8'd255};

    logic         clk_pixel;
    logic         recent_reset;
    logic         cam_valid_i;
    hcount_t      cam_hcount_i;
    vcount_t      cam_vcount_i;
    rgb565_t      cam_pixel_i;
    channel_sel_e channel_sel_i;
    bg_sel_e      bg_sel_i;
    target_sel_e  target_sel_i;
    channel_t     lower_i;
    channel_t     upper_i;
    rgb888_t      pixel_o;
    hcount_t      hcount_o;
    vcount_t      vcount_o;
    logic         active_o;
    logic         hsync_o;
    logic         vsync_o;

    // random stored frame, row-major
    rgb565_t model_frame [FRAME_WIDTH * FRAME_HEIGHT];
    int      cycle_count = 0;

    color_mask_top i_dut (
        .clk_pixel    (clk_pixel),
        .recent_reset (recent_reset),
        .cam_valid_i  (cam_valid_i),
        .cam_hcount_i (cam_hcount_i),
        .cam_vcount_i (cam_vcount_i),
        .cam_pixel_i  (cam_pixel_i),
        .channel_sel_i(channel_sel_i),
        .bg_sel_i     (bg_sel_i),
        .target_sel_i (target_sel_i),
        .lower_i      (lower_i),
        .upper_i      (upper_i),
        .pixel_o      (pixel_o),
        .hcount_o     (hcount_o),
        .vcount_o     (vcount_o),
        .active_o     (active_o),
        .hsync_o      (hsync_o),
        .vsync_o      (vsync_o)
    );

    initial begin
        clk_pixel = 1'b0;
        forever #2 clk_pixel = ~clk_pixel;
    end

    // run limit
    always @(posedge clk_pixel) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("Something failed");
            $fatal(1, "timeout, the run went past %0d cycles", CYCLE_LIMIT);
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("Something failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // reference pixel at raster h, v under the settings of one row
    function automatic rgb888_t expected_pixel(int h, int v, int row);
        rgb565_t px;
        int      r, g, b, y, cr, cb, sel;
        logic    m;
        rgb888_t out;
        // 4x scale and left to right mirror with black outside the frame
        if (h < CAM_WIDTH && v < CAM_HEIGHT) begin
            px = model_frame[(v / SCALE) * FRAME_WIDTH + FRAME_WIDTH - 1 - h / SCALE];
        end else begin
            px = '0;
        end
        // zero padded 565 expansion
        r = int'(px[15:11]) * 8;
        g = int'(px[10:5]) * 4;
        b = int'(px[4:0]) * 8;
        // floor division by 256 on signed sums
        y  = (((66 * r + 129 * g + 25 * b + 128) >>> 8) + 16) & 255;
        cr = (((112 * r - 94 * g - 18 * b + 128) >>> 8) + 128) & 255;
        cb = (((-38 * r - 74 * g + 112 * b + 128) >>> 8) + 128) & 255;
        case (CH_CODES[row])
            3'd0: sel = g;
            3'd1: sel = r;
            3'd2: sel = b;
            3'd4: sel = y;
            3'd5: sel = cr;
            3'd6: sel = cb;
            default: sel = 0;
        endcase
        m = (sel >= int'(LOWER[row])) && (sel <= int'(UPPER[row]));
        case (BG_CODES[row])
            2'd0: out = {8'(r), 8'(g), 8'(b)};
            2'd1: out = {3{8'(sel)}};
            2'd2: out = m ? 24'hFFFFFF : 24'h000000;
            default: out = {3{8'(y)}};
        endcase
        if (TGT_CODES[row] == 2'd1 && m) begin
            out = 24'hFF77AA;
        end
        return out;
    endfunction

    // sync flags stay low while the delay line fills and hcount_o then counts from zero
    task automatic check_reset_outputs();
        for (int i = 0; i < 8; i++) begin
            @(negedge clk_pixel);
            check_value("reset active_o", 32'd0, 32'(active_o));
            check_value("reset hsync_o", 32'd0, 32'(hsync_o));
            check_value("reset vsync_o", 32'd0, 32'(vsync_o));
        end
        for (int k = 0; k < 4; k++) begin
            @(negedge clk_pixel);
            check_value("reset hcount_o", 32'(k), 32'(hcount_o));
        end
    endtask

    // one 64 by 32 camera frame where each 4 by 4 block holds one stored value
    task automatic load_camera_frame();
        for (int v = 0; v < CAM_HEIGHT; v++) begin
            for (int h = 0; h < CAM_WIDTH; h++) begin
                @(posedge clk_pixel);
                cam_valid_i  <= 1'b1;
                cam_hcount_i <= hcount_t'(h);
                cam_vcount_i <= vcount_t'(v);
                cam_pixel_i  <= model_frame[(v / SCALE) * FRAME_WIDTH + h / SCALE];
            end
        end
        @(posedge clk_pixel);
        cam_valid_i <= 1'b0;
    endtask

    task automatic apply_row(int row);
        @(posedge clk_pixel);
        channel_sel_i <= channel_sel_e'(CH_CODES[row]);
        bg_sel_i      <= bg_sel_e'(BG_CODES[row]);
        target_sel_i  <= target_sel_e'(TGT_CODES[row]);
        lower_i       <= LOWER[row];
        upper_i       <= UPPER[row];
    endtask

    // returns on the first sample with vsync_o newly high
    task automatic wait_vsync_rise();
        logic prev;
        @(negedge clk_pixel);
        prev = vsync_o;
        @(negedge clk_pixel);
        while (!(vsync_o && !prev)) begin
            prev = vsync_o;
            @(negedge clk_pixel);
        end
    endtask

    // raster outputs and every visible pixel of one frame
    // tracking starts at the vsync rise, which is raster position 0, V_ACTIVE
    task automatic check_frame(int row);
        int      h;
        int      v;
        logic    visible;
        logic    hsync;
        logic    vsync;
        rgb888_t want;
        string   where;
        h = 0;
        v = V_ACTIVE;
        while (!(h == H_ACTIVE - 1 && v == V_ACTIVE - 1)) begin
            // next raster position
            if (h == H_TOTAL - 1) begin
                h = 0;
                v = (v == V_TOTAL - 1) ? 0 : v + 1;
            end else begin
                h++;
            end
            visible = (h < H_ACTIVE) && (v < V_ACTIVE);
            hsync   = (h >= H_ACTIVE) && (h < H_ACTIVE + H_SYNC);
            vsync   = (v >= V_ACTIVE) && (v < V_ACTIVE + V_SYNC);
            @(negedge clk_pixel);
            where = $sformatf("%s at %0d,%0d", test_names[row], h, v);
            check_value({where, " hcount_o"}, 32'(h), 32'(hcount_o));
            check_value({where, " vcount_o"}, 32'(v), 32'(vcount_o));
            check_value({where, " active_o"}, 32'(visible), 32'(active_o));
            check_value({where, " hsync_o"}, 32'(hsync), 32'(hsync_o));
            check_value({where, " vsync_o"}, 32'(vsync), 32'(vsync_o));
            if (visible) begin
                want = expected_pixel(h, v, row);
                check_value({where, " pixel_o"}, 32'(want), 32'(pixel_o));
            end
        end
    endtask

    initial begin
        void'($urandom(6));
        for (int i = 0; i < FRAME_WIDTH * FRAME_HEIGHT; i++) begin
            model_frame[i] = rgb565_t'($urandom);
        end
        recent_reset  <= 1'b1;
        cam_valid_i   <= 1'b0;
        cam_hcount_i  <= '0;
        cam_vcount_i  <= '0;
        cam_pixel_i   <= '0;
        channel_sel_i <= CH_GREEN;
        bg_sel_i      <= BG_CAMERA;
        target_sel_i  <= TGT_NONE;
        lower_i       <= '0;
        upper_i       <= '0;
        repeat (8) @(posedge clk_pixel);
        recent_reset <= 1'b0;
        check_reset_outputs();
        load_camera_frame();
        for (int row = 0; row < NUM_TESTS; row++) begin
            apply_row(row);
            wait_vsync_rise();
            check_frame(row);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== color_mask_top.sv ====
`timescale 1ns/1ps

module color_mask_top #(
    parameter int FRAME_WIDTH  = 16,
    parameter int FRAME_HEIGHT = 8,
    parameter int H_ACTIVE     = 72,
    parameter int H_TOTAL      = 88,
    parameter int V_ACTIVE     = 36,
    parameter int V_TOTAL      = 40
) (
    input  logic                   clk_pixel,
    input  logic                   recent_reset,
    input  logic                   cam_valid_i,
    input  mask_pkg::hcount_t      cam_hcount_i,
    input  mask_pkg::vcount_t      cam_vcount_i,
    input  mask_pkg::rgb565_t      cam_pixel_i,
    input  mask_pkg::channel_sel_e channel_sel_i,
    input  mask_pkg::bg_sel_e      bg_sel_i,
    input  mask_pkg::target_sel_e  target_sel_i,
    input  mask_pkg::channel_t     lower_i,
    input  mask_pkg::channel_t     upper_i,
    output mask_pkg::rgb888_t      pixel_o,
    output mask_pkg::hcount_t      hcount_o,
    output mask_pkg::vcount_t      vcount_o,
    output logic                   active_o,
    output logic                   hsync_o,
    output logic                   vsync_o
);

    import mask_pkg::*;

    localparam int ADDR_W = $clog2(FRAME_WIDTH * FRAME_HEIGHT);
    // pixel path latency from raster counters to pixel_o
    localparam int RASTER_DELAY = 8;
    localparam int RASTER_W = $bits(hcount_t) + $bits(vcount_t) + 3;

    hcount_t raster_hcount;
    vcount_t raster_vcount;
    logic    raster_active;
    logic    raster_hsync;
    logic    raster_vsync;

    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;
    rgb565_t           wr_data;
    rgb565_t           rd_data;

    channel_t fb_red, fb_green, fb_blue;
    channel_t y, cr, cb;
    channel_t mk_red, mk_green, mk_blue, mk_y, mk_channel;
    logic     mask;

    logic [RASTER_W-1:0] raster_dly [RASTER_DELAY];

    display_timing #(
        .H_ACTIVE(H_ACTIVE),
        .H_TOTAL (H_TOTAL),
        .V_ACTIVE(V_ACTIVE),
        .V_TOTAL (V_TOTAL)
    ) i_display_timing (
        .clk_pixel   (clk_pixel),
        .recent_reset(recent_reset),
        .hcount_o    (raster_hcount),
        .vcount_o    (raster_vcount),
        .active_o    (raster_active),
        .hsync_o     (raster_hsync),
        .vsync_o     (raster_vsync)
    );

    // camera side, downsample into the buffer
    frame_writer #(
        .FRAME_WIDTH (FRAME_WIDTH),
        .FRAME_HEIGHT(FRAME_HEIGHT)
    ) i_frame_writer (
        .clk_pixel   (clk_pixel),
        .recent_reset(recent_reset),
        .cam_valid_i (cam_valid_i),
        .cam_hcount_i(cam_hcount_i),
        .cam_vcount_i(cam_vcount_i),
        .cam_pixel_i (cam_pixel_i),
        .wr_en_o     (wr_en),
        .wr_addr_o   (wr_addr),
        .wr_data_o   (wr_data)
    );

    frame_buffer #(
        .FRAME_WIDTH (FRAME_WIDTH),
        .FRAME_HEIGHT(FRAME_HEIGHT)
    ) i_frame_buffer (
        .clk_pixel(clk_pixel),
        .wr_en_i  (wr_en),
        .wr_addr_i(wr_addr),
        .wr_data_i(wr_data),
        .rd_addr_i(rd_addr),
        .rd_data_o(rd_data)
    );

    // display side, rgb ready at t+3
    frame_reader #(
        .FRAME_WIDTH (FRAME_WIDTH),
        .FRAME_HEIGHT(FRAME_HEIGHT)
    ) i_frame_reader (
        .clk_pixel(clk_pixel),
        .hcount_i (raster_hcount),
        .vcount_i (raster_vcount),
        .rd_data_i(rd_data),
        .rd_addr_o(rd_addr),
        .red_o    (fb_red),
        .green_o  (fb_green),
        .blue_o   (fb_blue)
    );

    // ycrcb ready at t+6
    rgb_to_ycrcb i_rgb_to_ycrcb (
        .clk_pixel(clk_pixel),
        .red_i    (fb_red),
        .green_i  (fb_green),
        .blue_i   (fb_blue),
        .y_o      (y),
        .cr_o     (cr),
        .cb_o     (cb)
    );

    // mask and aligned colours at t+7
    channel_mask i_channel_mask (
        .clk_pixel    (clk_pixel),
        .recent_reset (recent_reset),
        .red_i        (fb_red),
        .green_i      (fb_green),
        .blue_i       (fb_blue),
        .y_i          (y),
        .cr_i         (cr),
        .cb_i         (cb),
        .channel_sel_i(channel_sel_i),
        .lower_i      (lower_i),
        .upper_i      (upper_i),
        .red_o        (mk_red),
        .green_o      (mk_green),
        .blue_o       (mk_blue),
        .y_o          (mk_y),
        .channel_o    (mk_channel),
        .mask_o       (mask)
    );

    // final pixel at t+8
    video_mux i_video_mux (
        .clk_pixel   (clk_pixel),
        .bg_sel_i    (bg_sel_i),
        .target_sel_i(target_sel_i),
        .red_i       (mk_red),
        .green_i     (mk_green),
        .blue_i      (mk_blue),
        .y_i         (mk_y),
        .channel_i   (mk_channel),
        .mask_i      (mask),
        .pixel_o     (pixel_o)
    );

    // raster signals delayed to match pixel_o
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            for (int i = 0; i < RASTER_DELAY; i++) begin
                raster_dly[i] <= '0;
            end
        end else begin
            raster_dly[0] <= {raster_hcount, raster_vcount,
                              raster_active, raster_hsync, raster_vsync};
            for (int i = 1; i < RASTER_DELAY; i++) begin
                raster_dly[i] <= raster_dly[i-1];
            end
        end
    end

    assign {hcount_o, vcount_o, active_o, hsync_o, vsync_o} = raster_dly[RASTER_DELAY-1];

endmodule

// ==== video_mux.sv ====
`timescale 1ns/1ps

module video_mux (
    input  logic                  clk_pixel,
    input  mask_pkg::bg_sel_e     bg_sel_i,
    input  mask_pkg::target_sel_e target_sel_i,
    input  mask_pkg::channel_t    red_i,
    input  mask_pkg::channel_t    green_i,
    input  mask_pkg::channel_t    blue_i,
    input  mask_pkg::channel_t    y_i,
    input  mask_pkg::channel_t    channel_i,
    input  logic                  mask_i,
    output mask_pkg::rgb888_t     pixel_o
);

    import mask_pkg::*;

    rgb888_t background;

    // background picture
    always_comb begin
        case (bg_sel_i)
            BG_CAMERA:  background = {red_i, green_i, blue_i};
            // grey from the selected channel
            BG_CHANNEL: background = {3{channel_i}};
            BG_MASK:    background = mask_i ? 24'hFFFFFF : 24'h000000;
            BG_LUMA:    background = {3{y_i}};
            default:    background = '0;
        endcase
    end

    // target colour painted over masked pixels
    always_ff @(posedge clk_pixel) begin
        if (target_sel_i == TGT_MASK && mask_i) begin
            pixel_o <= TARGET_COLOR;
        end else begin
            pixel_o <= background;
        end
    end

endmodule

// ==== channel_mask.sv ====
`timescale 1ns/1ps

module channel_mask (
    input  logic                   clk_pixel,
    input  logic                   recent_reset,
    input  mask_pkg::channel_t     red_i,
    input  mask_pkg::channel_t     green_i,
    input  mask_pkg::channel_t     blue_i,
    input  mask_pkg::channel_t     y_i,
    input  mask_pkg::channel_t     cr_i,
    input  mask_pkg::channel_t     cb_i,
    input  mask_pkg::channel_sel_e channel_sel_i,
    input  mask_pkg::channel_t     lower_i,
    input  mask_pkg::channel_t     upper_i,
    output mask_pkg::channel_t     red_o,
    output mask_pkg::channel_t     green_o,
    output mask_pkg::channel_t     blue_o,
    output mask_pkg::channel_t     y_o,
    output mask_pkg::channel_t     channel_o,
    output logic                   mask_o
);

    import mask_pkg::*;

    // rgb arrives 3 cycles ahead of ycrcb, one more to leave with the mask
    localparam int RGB_DELAY = 4;
    localparam int SEL_TAP   = RGB_DELAY - 2;

    rgb888_t  rgb_dly [RGB_DELAY];
    rgb888_t  rgb_sel;
    channel_t selected;

    always_ff @(posedge clk_pixel) begin
        rgb_dly[0] <= {red_i, green_i, blue_i};
        for (int i = 1; i < RGB_DELAY; i++) begin
            rgb_dly[i] <= rgb_dly[i-1];
        end
    end

    // rgb tap that lines up with y, cr and cb
    assign rgb_sel = rgb_dly[SEL_TAP];

    always_comb begin
        case (channel_sel_i)
            CH_GREEN: selected = rgb_sel[15:8];
            CH_RED:   selected = rgb_sel[23:16];
            CH_BLUE:  selected = rgb_sel[7:0];
            CH_Y:     selected = y_i;
            CH_CR:    selected = cr_i;
            CH_CB:    selected = cb_i;
            // invalid codes
            default:  selected = '0;
        endcase
    end

    // inclusive window on the selected channel
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            mask_o <= 1'b0;
        end else begin
            mask_o <= (selected >= lower_i) && (selected <= upper_i);
        end
    end

    always_ff @(posedge clk_pixel) begin
        channel_o <= selected;
        y_o       <= y_i;
    end

    assign {red_o, green_o, blue_o} = rgb_dly[RGB_DELAY-1];

endmodule

// ==== rgb_to_ycrcb.sv ====
`timescale 1ns/1ps

module rgb_to_ycrcb (
    input  logic               clk_pixel,
    input  mask_pkg::channel_t red_i,
    input  mask_pkg::channel_t green_i,
    input  mask_pkg::channel_t blue_i,
    output mask_pkg::channel_t y_o,
    output mask_pkg::channel_t cr_o,
    output mask_pkg::channel_t cb_o
);

    import mask_pkg::*;

    // products and sums fit in 18 signed bits
    typedef logic signed [17:0] product_t;
    typedef logic signed [9:0]  scaled_t;

    logic signed [8:0] r_s, g_s, b_s;
    product_t y_r, y_g, y_b;
    product_t cr_r, cr_g, cr_b;
    product_t cb_r, cb_g, cb_b;
    product_t y_sum, cr_sum, cb_sum;
    scaled_t  y_q, cr_q, cb_q;
    scaled_t  y_full, cr_full, cb_full;

    // inputs as positive signed values
    assign r_s = $signed({1'b0, red_i});
    assign g_s = $signed({1'b0, green_i});
    assign b_s = $signed({1'b0, blue_i});

    // stage one, nine products
    always_ff @(posedge clk_pixel) begin
        y_r  <= r_s * Y_R;
        y_g  <= g_s * Y_G;
        y_b  <= b_s * Y_B;
        cr_r <= r_s * CR_R;
        cr_g <= g_s * CR_G;
        cr_b <= b_s * CR_B;
        cb_r <= r_s * CB_R;
        cb_g <= g_s * CB_G;
        cb_b <= b_s * CB_B;
    end

    // +128 rounds before the divide by 256
    assign y_sum  = y_r + y_g + y_b + 18'sd128;
    assign cr_sum = cr_r + cr_g + cr_b + 18'sd128;
    assign cb_sum = cb_r + cb_g + cb_b + 18'sd128;

    // stage two, arithmetic shift floors negative chroma
    always_ff @(posedge clk_pixel) begin
        y_q  <= scaled_t'(y_sum >>> 8);
        cr_q <= scaled_t'(cr_sum >>> 8);
        cb_q <= scaled_t'(cb_sum >>> 8);
    end

    assign y_full  = y_q + Y_OFFSET;
    assign cr_full = cr_q + C_OFFSET;
    assign cb_full = cb_q + C_OFFSET;

    // stage three, offsets added and low byte kept
    always_ff @(posedge clk_pixel) begin
        y_o  <= y_full[7:0];
        cr_o <= cr_full[7:0];
        cb_o <= cb_full[7:0];
    end

endmodule

// ==== frame_reader.sv ====
`timescale 1ns/1ps

module frame_reader #(
    parameter int FRAME_WIDTH  = 16,
    parameter int FRAME_HEIGHT = 8,
    localparam int ADDR_W = $clog2(FRAME_WIDTH * FRAME_HEIGHT)
) (
    input  logic               clk_pixel,
    input  mask_pkg::hcount_t  hcount_i,
    input  mask_pkg::vcount_t  vcount_i,
    input  mask_pkg::rgb565_t  rd_data_i,
    output logic [ADDR_W-1:0]  rd_addr_o,
    output mask_pkg::channel_t red_o,
    output mask_pkg::channel_t green_o,
    output mask_pkg::channel_t blue_o
);

    import mask_pkg::*;

    // raster area covered by the scaled frame
    localparam int REGION_W = FRAME_WIDTH << SCALE_SHIFT;
    localparam int REGION_H = FRAME_HEIGHT << SCALE_SHIFT;

    hcount_t col_scaled;
    vcount_t row_scaled;
    logic    in_region_q1;
    logic    in_region_q2;

    assign col_scaled = hcount_i >> SCALE_SHIFT;
    assign row_scaled = vcount_i >> SCALE_SHIFT;

    // address and region flag at t+1
    // column mirrored so the picture reads like a mirror
    always_ff @(posedge clk_pixel) begin
        rd_addr_o <= ADDR_W'(FRAME_WIDTH - 1 - int'(col_scaled)
                             + FRAME_WIDTH * int'(row_scaled));
        in_region_q1 <= (int'(hcount_i) < REGION_W) && (int'(vcount_i) < REGION_H);
    end

    // flag waits one cycle for the ram data
    always_ff @(posedge clk_pixel) begin
        in_region_q2 <= in_region_q1;
    end

    // 565 to 888 by zero padding, black outside the frame
    always_ff @(posedge clk_pixel) begin
        red_o   <= in_region_q2 ? {rd_data_i[15:11], 3'b000} : '0;
        green_o <= in_region_q2 ? {rd_data_i[10:5], 2'b00} : '0;
        blue_o  <= in_region_q2 ? {rd_data_i[4:0], 3'b000} : '0;
    end

endmodule

// ==== frame_buffer.sv ====
`timescale 1ns/1ps

module frame_buffer #(
    parameter int FRAME_WIDTH  = 16,
    parameter int FRAME_HEIGHT = 8,
    localparam int DEPTH  = FRAME_WIDTH * FRAME_HEIGHT,
    localparam int ADDR_W = $clog2(DEPTH)
) (
    input  logic              clk_pixel,
    input  logic              wr_en_i,
    input  logic [ADDR_W-1:0] wr_addr_i,
    input  mask_pkg::rgb565_t wr_data_i,
    input  logic [ADDR_W-1:0] rd_addr_i,
    output mask_pkg::rgb565_t rd_data_o
);

    import mask_pkg::*;

    // one word per stored pixel
    rgb565_t mem [DEPTH];

    // write port
    always_ff @(posedge clk_pixel) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read, one cycle of latency
    always_ff @(posedge clk_pixel) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

// ==== frame_writer.sv ====
`timescale 1ns/1ps

module frame_writer #(
    parameter int FRAME_WIDTH  = 16,
    parameter int FRAME_HEIGHT = 8,
    localparam int ADDR_W = $clog2(FRAME_WIDTH * FRAME_HEIGHT)
) (
    input  logic              clk_pixel,
    input  logic              recent_reset,
    input  logic              cam_valid_i,
    input  mask_pkg::hcount_t cam_hcount_i,
    input  mask_pkg::vcount_t cam_vcount_i,
    input  mask_pkg::rgb565_t cam_pixel_i,
    output logic              wr_en_o,
    output logic [ADDR_W-1:0] wr_addr_o,
    output mask_pkg::rgb565_t wr_data_o
);

    import mask_pkg::*;

    logic keep;

    // every fourth column of every fourth line
    assign keep = cam_valid_i
                  && (cam_hcount_i[SCALE_SHIFT-1:0] == '0)
                  && (cam_vcount_i[SCALE_SHIFT-1:0] == '0);

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            wr_en_o   <= 1'b0;
            wr_addr_o <= '0;
        end else begin
            wr_en_o <= keep;
            if (keep) begin
                // top left corner restarts the row-major fill
                if (cam_hcount_i == '0 && cam_vcount_i == '0) begin
                    wr_addr_o <= '0;
                end else begin
                    wr_addr_o <= wr_addr_o + 1'b1;
                end
            end
        end
    end

    // pixel data rides along with the strobe
    always_ff @(posedge clk_pixel) begin
        if (keep) begin
            wr_data_o <= cam_pixel_i;
        end
    end

endmodule

// ==== display_timing.sv ====
`timescale 1ns/1ps

module display_timing #(
    parameter int H_ACTIVE = 72,
    parameter int H_TOTAL  = 88,
    parameter int V_ACTIVE = 36,
    parameter int V_TOTAL  = 40
) (
    input  logic              clk_pixel,
    input  logic              recent_reset,
    output mask_pkg::hcount_t hcount_o,
    output mask_pkg::vcount_t vcount_o,
    output logic              active_o,
    output logic              hsync_o,
    output logic              vsync_o
);

    import mask_pkg::*;

    // sync pulses sit right after the visible area
    localparam int H_SYNC = 8;
    localparam int V_SYNC = 2;
    localparam hcount_t H_LAST = hcount_t'(H_TOTAL - 1);
    localparam vcount_t V_LAST = vcount_t'(V_TOTAL - 1);

    hcount_t h_next;
    vcount_t v_next;

    // next raster position, wrapping at both ends
    always_comb begin
        h_next = (hcount_o == H_LAST) ? '0 : hcount_o + 1'b1;
        v_next = vcount_o;
        if (hcount_o == H_LAST) begin
            v_next = (vcount_o == V_LAST) ? '0 : vcount_o + 1'b1;
        end
    end

    // flags come from the next position so they line up with the counters
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            hcount_o <= '0;
            vcount_o <= '0;
            active_o <= 1'b0;
            hsync_o  <= 1'b0;
            vsync_o  <= 1'b0;
        end else begin
            hcount_o <= h_next;
            vcount_o <= v_next;
            active_o <= (int'(h_next) < H_ACTIVE) && (int'(v_next) < V_ACTIVE);
            hsync_o  <= (int'(h_next) >= H_ACTIVE) && (int'(h_next) < H_ACTIVE + H_SYNC);
            vsync_o  <= (int'(v_next) >= V_ACTIVE) && (int'(v_next) < V_ACTIVE + V_SYNC);
        end
    end

endmodule

// ==== mask_pkg.sv ====
package mask_pkg;

    // pixel and position types
    typedef logic [15:0] rgb565_t;
    typedef logic [7:0]  channel_t;
    typedef logic [23:0] rgb888_t;
    typedef logic [10:0] hcount_t;
    typedef logic [9:0]  vcount_t;

    // channel codes, 3 and 7 have no name and select zero
    typedef enum logic [2:0] {
        CH_GREEN = 3'd0,
        CH_RED   = 3'd1,
        CH_BLUE  = 3'd2,
        CH_Y     = 3'd4,
        CH_CR    = 3'd5,
        CH_CB    = 3'd6
    } channel_sel_e;

    // background modes
    typedef enum logic [1:0] {
        BG_CAMERA  = 2'd0,
        BG_CHANNEL = 2'd1,
        BG_MASK    = 2'd2,
        BG_LUMA    = 2'd3
    } bg_sel_e;

    // target modes, 2 and 3 act like none
    typedef enum logic [1:0] {
        TGT_NONE = 2'd0,
        TGT_MASK = 2'd1
    } target_sel_e;

    // overlay colour for masked pixels
    localparam rgb888_t TARGET_COLOR = 24'hFF77AA;

    // bt.601 coefficients scaled by 256
    localparam logic signed [8:0] Y_R  = 9'sd66;
    localparam logic signed [8:0] Y_G  = 9'sd129;
    localparam logic signed [8:0] Y_B  = 9'sd25;
    localparam logic signed [8:0] CR_R = 9'sd112;
    localparam logic signed [8:0] CR_G = -9'sd94;
    localparam logic signed [8:0] CR_B = -9'sd18;
    localparam logic signed [8:0] CB_R = -9'sd38;
    localparam logic signed [8:0] CB_G = -9'sd74;
    localparam logic signed [8:0] CB_B = 9'sd112;
    localparam logic signed [8:0] Y_OFFSET = 9'sd16;
    localparam logic signed [8:0] C_OFFSET = 9'sd128;

    // one stored pixel covers 4 by 4 raster pixels
    localparam int SCALE_SHIFT = 2;

endpackage
